//--- arith_sequencer.sv
// Host-facing sequencer.
// Accepts one request while idle, launches the selected unit, then
// registers the chosen answer with ack and the status flags.

module arith_sequencer (
  input  logic                 clk,
  input  logic                 ar,
  input  logic                 req,
  input  int_arith_pkg::op_e   op,
  input  int_arith_pkg::word_t a,
  input  int_arith_pkg::word_t b,
  output logic                 ack,
  output logic                 busy,
  output int_arith_pkg::word_t result,
  output logic                 carry,
  output logic                 overflow,
  output logic                 div_zero,
  op_if.host                   add_bus,
  op_if.host                   mul_bus,
  op_if.host                   div_bus,
  output logic                 mul_signed,
  output logic                 div_signed
);

  localparam int W = int_arith_pkg::WIDTH;

  int_arith_pkg::op_e   op_q;      // Operation in flight.
  logic                 accept;
  logic                 unit_done; // Only one unit can be active.
  logic                 is_div_q;  // Divide or remainder pending.
  int_arith_pkg::word_t sel_word;

  assign accept = req && !busy; // A busy request is dropped here.

  // ----------------------------------------------------------
  // Launch side.
  assign add_bus.req = accept && (op == int_arith_pkg::OP_ADD);
  assign mul_bus.req = accept && (op inside {int_arith_pkg::OP_MUL_LO,
                                             int_arith_pkg::OP_MUL_HI_U,
                                             int_arith_pkg::OP_MUL_HI_S});
  assign div_bus.req = accept && (op inside {int_arith_pkg::OP_DIV_U, int_arith_pkg::OP_DIV_S,
                                             int_arith_pkg::OP_REM_U, int_arith_pkg::OP_REM_S});
  assign add_bus.a = a;
  assign add_bus.b = b;
  assign mul_bus.a = a;
  assign mul_bus.b = b;
  assign div_bus.a = a;
  assign div_bus.b = b;

  assign mul_signed = (op == int_arith_pkg::OP_MUL_HI_S);
  assign div_signed = (op == int_arith_pkg::OP_DIV_S) || (op == int_arith_pkg::OP_REM_S);

  // ----------------------------------------------------------
  // Answer side.
  assign unit_done = add_bus.done || mul_bus.done || div_bus.done;
  assign is_div_q  = op_q inside {int_arith_pkg::OP_DIV_U, int_arith_pkg::OP_DIV_S,
                                  int_arith_pkg::OP_REM_U, int_arith_pkg::OP_REM_S};

  always_comb begin
    unique case (op_q)
      int_arith_pkg::OP_ADD:    sel_word = add_bus.result.sum;
      int_arith_pkg::OP_MUL_LO: sel_word = mul_bus.result[W-1:0];
      int_arith_pkg::OP_MUL_HI_U,
      int_arith_pkg::OP_MUL_HI_S: sel_word = mul_bus.result[2*W-1:W];
      int_arith_pkg::OP_DIV_U,
      int_arith_pkg::OP_DIV_S:  sel_word = div_bus.result.quotient;
      default:                  sel_word = div_bus.result.remainder; // Remainder ops.
    endcase
  end

  always_ff @(posedge clk or posedge ar) begin
    if (ar) begin
      op_q     <= int_arith_pkg::OP_ADD;
      busy     <= 1'b0;
      ack      <= 1'b0;
      result   <= '0;
      carry    <= 1'b0;
      overflow <= 1'b0;
      div_zero <= 1'b0;
    end else begin
      ack <= unit_done; // One cycle behind the unit.
      if (accept) begin
        busy <= 1'b1;
        op_q <= op;
      end else if (ack) begin
        busy <= 1'b0;   // Free from the cycle after ack.
      end
      if (unit_done) begin
        result   <= sel_word;
        carry    <= (op_q == int_arith_pkg::OP_ADD) && add_bus.result.carry;
        overflow <= (op_q == int_arith_pkg::OP_ADD) && add_bus.result.overflow;
        div_zero <= is_div_q && div_bus.result.div_zero;
      end
    end
  end

  // A dropped request launches no unit, so answers come only inside a pending operation.
  a_busy_req_ignored: assert property (@(posedge clk) disable iff (ar)
    unit_done |-> busy && !ack)
    else $error("unit answered outside a pending operation");

  // Each ack closes an accepted operation.
  a_ack_in_busy: assert property (@(posedge clk) disable iff (ar)
    ack |-> busy)
    else $error("ack without a pending operation");

endmodule

//--- arith_unit.sv
// Integer arithmetic coprocessor top level.
// Sequencer plus adder, pipelined multiplier and signed divider.

module arith_unit #(
  parameter int width       = int_arith_pkg::WIDTH,
  parameter int mul_latency = int_arith_pkg::MUL_LATENCY
) (
  input  logic                 clk,
  input  logic                 ar,
  input  logic                 req,
  input  int_arith_pkg::op_e   op,
  input  int_arith_pkg::word_t a,
  input  int_arith_pkg::word_t b,
  output logic                 ack,
  output logic                 busy,
  output int_arith_pkg::word_t result,
  output logic                 carry,
  output logic                 overflow,
  output logic                 div_zero
);

  logic mul_signed; // Multiplier extension mode.
  logic div_signed; // Divider sign correction on.

  // ----------------------------------------------------------
  // Unit buses.
  op_if #(.result_t(int_arith_pkg::add_res_t))    add_bus ();
  op_if #(.result_t(int_arith_pkg::dword_t))      mul_bus ();
  op_if #(.result_t(int_arith_pkg::divmod_res_t)) div_bus ();

  arith_sequencer i_arith_sequencer (
    .clk       (clk),
    .ar        (ar),
    .req       (req),
    .op        (op),
    .a         (a),
    .b         (b),
    .ack       (ack),
    .busy      (busy),
    .result    (result),
    .carry     (carry),
    .overflow  (overflow),
    .div_zero  (div_zero),
    .add_bus   (add_bus.host),
    .mul_bus   (mul_bus.host),
    .div_bus   (div_bus.host),
    .mul_signed(mul_signed),
    .div_signed(div_signed)
  );

  overflow_adder i_overflow_adder (
    .clk(clk),
    .ar (ar),
    .bus(add_bus.unit)
  );

  pipe_multiplier #(
    .latency(mul_latency)
  ) i_pipe_multiplier (
    .clk      (clk),
    .ar       (ar),
    .is_signed(mul_signed),
    .bus      (mul_bus.unit)
  );

  signed_divmod #(
    .width(width)
  ) i_signed_divmod (
    .clk      (clk),
    .ar       (ar),
    .is_signed(div_signed),
    .bus      (div_bus.unit)
  );

endmodule

//--- divmod_core.sv
// Unsigned variable-latency radix-2 divider.
// Preshift aligns the divisor under the dividend, then one subtract per bit.
// Divisors of zero and one finish in a single cycle.

module divmod_core #(
  parameter int width = int_arith_pkg::WIDTH
) (
  input  logic                 clk,
  input  logic                 ar,
  input  logic                 req,       // Accepted only when idle.
  input  int_arith_pkg::word_t n,         // Dividend.
  input  int_arith_pkg::word_t d,         // Divisor.
  output logic                 done,      // One-cycle end marker.
  output int_arith_pkg::word_t quotient,
  output int_arith_pkg::word_t remainder,
  output logic                 div_zero
);

  typedef enum logic [1:0] {
    PH_IDLE,
    PH_PRESHIFT,
    PH_STEP
  } phase_e;

  phase_e           phase_q;
  logic [width-1:0] dd_q;       // Working divisor.
  logic [width-1:0] nn_q;       // Partial remainder.
  logic [width-1:0] pp_q;       // Quotient position bit.
  logic [width-1:0] rr_q;       // Quotient being built.
  logic             shortcut;   // Divisor zero or one.
  logic             aligned;    // Preshift has gone far enough.

  assign shortcut = (d <= width'(1));
  assign aligned  = dd_q[width-1] || (dd_q >= nn_q);

  // ----------------------------------------------------------
  // Phase control.
  always_ff @(posedge clk or posedge ar) begin
    if (ar) begin
      phase_q  <= PH_IDLE;
      done     <= 1'b0;
      div_zero <= 1'b0;
    end else begin
      done <= 1'b0; // Pulse only.
      unique case (phase_q)
        PH_IDLE: begin
          if (req) begin
            div_zero <= (d == '0);
            if (shortcut) begin
              done <= 1'b1;           // Answer is ready next cycle.
            end else begin
              phase_q <= PH_PRESHIFT;
            end
          end
        end
        PH_PRESHIFT: begin
          if (aligned) phase_q <= PH_STEP;
        end
        PH_STEP: begin
          if (pp_q == width'(1)) begin // Last quotient bit.
            phase_q <= PH_IDLE;
            done    <= 1'b1;
          end
        end
        default: phase_q <= PH_IDLE;
      endcase
    end
  end

  // ----------------------------------------------------------
  // Datapath.
  always_ff @(posedge clk) begin
    unique case (phase_q)
      PH_IDLE: begin
        if (req) begin
          dd_q <= d;
          pp_q <= width'(1);
          // Zero gives all ones, one gives n, else start from zero.
          rr_q <= (d == '0) ? '1 : ((d == width'(1)) ? n : '0);
          nn_q <= (d == width'(1)) ? '0 : n;
        end
      end
      PH_PRESHIFT: begin
        if (!aligned) begin
          dd_q <= dd_q << 1;
          pp_q <= pp_q << 1;
        end
      end
      PH_STEP: begin
        if (nn_q >= dd_q) begin
          rr_q <= rr_q | pp_q;
          nn_q <= nn_q - dd_q;
        end
        dd_q <= dd_q >> 1;
        pp_q <= pp_q >> 1;
      end
      default: ;
    endcase
  end

  assign quotient  = rr_q;
  assign remainder = nn_q;

  // The sequencer must never launch into a running division.
  a_req_when_idle: assert property (@(posedge clk) disable iff (ar)
    req |-> phase_q == PH_IDLE)
    else $error("divider req while not idle");

endmodule

//--- int_arith_pkg.sv
// Integer arithmetic coprocessor shared definitions.
// Widths, operation codes and the result payloads carried on the unit buses.

package int_arith_pkg;

  // ----------------------------------------------------------
  // Sizes.
  parameter int WIDTH       = 32; // Operand and result word.
  parameter int MUL_LATENCY = 3;  // Multiplier core depth in cycles.

  typedef logic [WIDTH-1:0]   word_t;
  typedef logic [2*WIDTH-1:0] dword_t; // Full product.

  // ----------------------------------------------------------
  // Operation codes as seen by the host.
  typedef enum logic [2:0] {
    OP_ADD      = 3'd0,
    OP_MUL_LO   = 3'd1, // Low word, sign does not matter.
    OP_MUL_HI_U = 3'd2,
    OP_MUL_HI_S = 3'd3,
    OP_DIV_U    = 3'd4,
    OP_DIV_S    = 3'd5,
    OP_REM_U    = 3'd6,
    OP_REM_S    = 3'd7
  } op_e;

  // Adder answer.
  typedef struct packed {
    word_t sum;
    logic  carry;    // Unsigned carry out.
    logic  overflow; // Signed overflow.
  } add_res_t;

  // Divider answer, both halves at once.
  typedef struct packed {
    word_t quotient;
    word_t remainder;
    logic  div_zero;
  } divmod_res_t;

endpackage

//--- list.f
+incdir+.
int_arith_pkg.sv
op_if.sv
overflow_adder.sv
pipe_multiplier.sv
divmod_core.sv
signed_divmod.sv
arith_sequencer.sv
arith_unit.sv
tb_arith_unit.sv

//--- op_if.sv
// Request/done bus between the sequencer and one arithmetic unit.
// req pulses for one cycle with a and b valid; done pulses with result valid.
// The result type differs per unit, hence the type parameter.

interface op_if #(
  parameter type result_t = int_arith_pkg::word_t
);

  logic                 req;    // One-cycle launch pulse.
  int_arith_pkg::word_t a;      // First operand.
  int_arith_pkg::word_t b;      // Second operand.
  logic                 done;   // One-cycle completion pulse.
  result_t              result; // Valid while done is high.

  // Sequencer side.
  modport host (
    output req, a, b,
    input  done, result
  );

  // Arithmetic unit side.
  modport unit (
    input  req, a, b,
    output done, result
  );

endinterface

//--- overflow_adder.sv
// Registered adder.
// Sum, unsigned carry and signed overflow appear one cycle after req.

module overflow_adder (
  input  logic clk,
  input  logic ar,
  op_if.unit   bus
);

  int_arith_pkg::word_t          a_q;   // Captured operands.
  int_arith_pkg::word_t          b_q;
  logic                          req_q; // Launch, one cycle late.
  logic [int_arith_pkg::WIDTH:0] wide;  // Sum with carry bit on top.
  int_arith_pkg::add_res_t       res;

  always_ff @(posedge clk or posedge ar) begin
    if (ar) begin
      req_q <= 1'b0;
    end else begin
      req_q <= bus.req;
    end
  end

  // Operands are payload only.
  always_ff @(posedge clk) begin
    if (bus.req) begin
      a_q <= bus.a;
      b_q <= bus.b;
    end
  end

  assign wide = {1'b0, a_q} + {1'b0, b_q};

  always_comb begin
    res.sum      = wide[int_arith_pkg::WIDTH-1:0];
    res.carry    = wide[int_arith_pkg::WIDTH]; // Bit above the word.
    // Same operand signs, different result sign.
    res.overflow = (a_q[int_arith_pkg::WIDTH-1] == b_q[int_arith_pkg::WIDTH-1]) &&
                   (wide[int_arith_pkg::WIDTH-1] != a_q[int_arith_pkg::WIDTH-1]);
  end

  assign bus.done   = req_q;
  assign bus.result = res;

endmodule

//--- pipe_multiplier.sv
// Fully pipelined multiplier, signed or unsigned, double-width product.
// Operands are extended and registered, multiplied, then delayed so that
// the product leaves latency cycles after req. Items may overlap.

module pipe_multiplier #(
  parameter int latency = int_arith_pkg::MUL_LATENCY
) (
  input  logic clk,
  input  logic ar,
  input  logic is_signed, // Valid with req.
  op_if.unit   bus
);

  localparam int W = int_arith_pkg::WIDTH;

  int_arith_pkg::dword_t ext_a_q; // Extended operands, first stage.
  int_arith_pkg::dword_t ext_b_q;
  int_arith_pkg::dword_t prod;    // Low 2W bits are right for either sign.
  logic [latency-1:0]    vld_q;   // Valid bit beside each stage.

  // ----------------------------------------------------------
  // Valid chain.
  always_ff @(posedge clk or posedge ar) begin
    if (ar) begin
      vld_q <= '0;
    end else begin
      vld_q <= (vld_q << 1) | latency'(bus.req); // One stage per cycle.
    end
  end

  // Sign or zero extension happens on the way in.
  always_ff @(posedge clk) begin
    ext_a_q <= is_signed ? {{W{bus.a[W-1]}}, bus.a} : {{W{1'b0}}, bus.a};
    ext_b_q <= is_signed ? {{W{bus.b[W-1]}}, bus.b} : {{W{1'b0}}, bus.b};
  end

  assign prod = ext_a_q * ext_b_q;

  // ----------------------------------------------------------
  // Delay line to the full latency.
  if (latency == 1) begin : g_direct
    assign bus.result = prod;
  end else begin : g_pipe
    int_arith_pkg::dword_t pipe_q [latency-1];
    always_ff @(posedge clk) begin
      pipe_q[0] <= prod;
      for (int i = 1; i < latency - 1; i++) begin
        pipe_q[i] <= pipe_q[i-1]; // Plain shift.
      end
    end
    assign bus.result = pipe_q[latency-2];
  end

  assign bus.done = vld_q[latency-1];

  // Every product leaving the pipe was launched exactly latency cycles before.
  a_done_has_req: assert property (@(posedge clk) disable iff (ar)
    bus.done |-> $past(bus.req, latency))
    else $error("multiplier done without matching req");

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build the coprocessor testbench with Verilator, run it and judge the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
  -f list.f --top-module tb_arith_unit -o tb_arith_unit_sim \
  || { echo "Verilator build failed"; exit 1; }
./obj_dir/tb_arith_unit_sim > sim.log 2>&1
cat sim.log
grep -q "Simulation finished: FAIL" sim.log && { echo "Run reported failure"; exit 1; }
grep -q "Simulation finished: PASS" sim.log || { echo "Run ended without a verdict"; exit 1; }
echo "Run passed"

//--- signed_divmod.sv
// Signed wrapper around the unsigned divider.
// Magnitudes go in; quotient rounds towards zero and the remainder
// follows the dividend's sign. Divide by zero bypasses correction.

module signed_divmod #(
  parameter int width = int_arith_pkg::WIDTH
) (
  input  logic clk,
  input  logic ar,
  input  logic is_signed, // Valid with req.
  op_if.unit   bus
);

  logic [width-1:0]          n_mag;    // Core operands.
  logic [width-1:0]          d_mag;
  logic [width-1:0]          n_orig_q; // Dividend as given.
  logic                      neg_q_q;  // Signs differed.
  logic                      neg_r_q;  // Dividend was negative.
  int_arith_pkg::word_t      core_q;
  int_arith_pkg::word_t      core_r;
  logic                      core_zero;
  int_arith_pkg::divmod_res_t res;

  assign n_mag = (is_signed && bus.a[width-1]) ? -bus.a : bus.a;
  assign d_mag = (is_signed && bus.b[width-1]) ? -bus.b : bus.b;

  // Sign record, control state.
  always_ff @(posedge clk or posedge ar) begin
    if (ar) begin
      neg_q_q <= 1'b0;
      neg_r_q <= 1'b0;
    end else if (bus.req) begin
      neg_q_q <= is_signed && (bus.a[width-1] ^ bus.b[width-1]);
      neg_r_q <= is_signed && bus.a[width-1];
    end
  end

  always_ff @(posedge clk) begin
    if (bus.req) n_orig_q <= bus.a; // For the divide-by-zero answer.
  end

  divmod_core #(
    .width(width)
  ) i_divmod_core (
    .clk      (clk),
    .ar       (ar),
    .req      (bus.req),
    .n        (n_mag),
    .d        (d_mag),
    .done     (bus.done),
    .quotient (core_q),
    .remainder(core_r),
    .div_zero (core_zero)
  );

  always_comb begin
    res.div_zero = core_zero;
    if (core_zero) begin
      res.quotient  = '1;
      res.remainder = n_orig_q;
    end else begin
      res.quotient  = neg_q_q ? -core_q : core_q;
      res.remainder = neg_r_q ? -core_r : core_r; // C rule.
    end
  end

  assign bus.result = res;

endmodule

//--- tb_arith_ref.svh
// Reference model, random source and compare task for the coprocessor testbench.
// Included inside the testbench module, after its counters are declared.

`ifndef TB_ARITH_REF_SVH
`define TB_ARITH_REF_SVH

  // Expected answer of one request.
  typedef struct packed {
    int_arith_pkg::word_t result;
    logic                 carry;
    logic                 overflow;
    logic                 div_zero;
  } expect_t;

  // ----------------------------------------------------------
  // Linear congruential generator, halves swapped for better low bits.
  function automatic int_arith_pkg::word_t next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {lcg_state[15:0], lcg_state[31:16]};
  endfunction

  // Answer of one operation from the coprocessor's arithmetic rules.
  function automatic expect_t reference_result(input int_arith_pkg::op_e o,
                                               input int_arith_pkg::word_t x,
                                               input int_arith_pkg::word_t y);
    expect_t     e;
    logic [32:0] wide;   // Sum plus carry.
    logic [63:0] prod;
    longint      sum_s;  // Exact signed sum.
    longint      sx;
    longint      sy;
    longint      q;
    longint      r;
    e = '0;
    case (o)
      int_arith_pkg::OP_ADD: begin
        wide       = {1'b0, x} + {1'b0, y};
        sum_s      = longint'($signed(x)) + longint'($signed(y));
        e.result   = wide[31:0];
        e.carry    = wide[32];
        // Signed sum outside the 32-bit range.
        e.overflow = (sum_s > 64'sd2147483647) || (sum_s < -64'sd2147483648);
      end
      int_arith_pkg::OP_MUL_LO, int_arith_pkg::OP_MUL_HI_U: begin
        prod     = {32'd0, x} * {32'd0, y};
        e.result = (o == int_arith_pkg::OP_MUL_LO) ? prod[31:0] : prod[63:32];
      end
      int_arith_pkg::OP_MUL_HI_S: begin
        prod     = longint'($signed(x)) * longint'($signed(y));
        e.result = prod[63:32];
      end
      default: begin // Divide and remainder.
        if (o == int_arith_pkg::OP_DIV_S || o == int_arith_pkg::OP_REM_S) begin
          sx = longint'($signed(x));
          sy = longint'($signed(y));
        end else begin
          sx = longint'(x);
          sy = longint'(y);
        end
        if (y == '0) begin
          e.div_zero = 1'b1;
          q          = -1;       // All ones.
          r          = sx;       // Dividend as given.
        end else begin
          q = sx / sy;           // Truncates towards zero.
          r = sx % sy;           // Sign of the dividend.
        end
        e.result = (o == int_arith_pkg::OP_DIV_U || o == int_arith_pkg::OP_DIV_S) ?
                   q[31:0] : r[31:0];
      end
    endcase
    return e;
  endfunction

  // Cycles from req to ack, or -1 where the divider's latency varies.
  function automatic int expected_latency(input int_arith_pkg::op_e o,
                                          input int_arith_pkg::word_t y);
    if (o == int_arith_pkg::OP_ADD) return 2;
    if (o inside {int_arith_pkg::OP_MUL_LO, int_arith_pkg::OP_MUL_HI_U,
                  int_arith_pkg::OP_MUL_HI_S}) return int_arith_pkg::MUL_LATENCY + 1;
    if (y <= 32'd1) return 2; // Shortcut divisors.
    if ((o == int_arith_pkg::OP_DIV_S || o == int_arith_pkg::OP_REM_S) && y == '1) return 2;
    return -1;
  endfunction

  // Compare one value and report a mismatch.
  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

`endif

//--- tb_arith_unit.sv
// Testbench for the integer arithmetic coprocessor.
// Issues add, multiply and divide requests and checks each ack against a
// reference model, with latency, busy and dropped busy requests.

module tb_arith_unit;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 16;
  localparam int N_RANDOM     = 24;                // Random items per group.
  localparam int NUM_TESTS    = 8 * N_RANDOM + 58; // Sum of all groups below.
  localparam int MAX_CYCLES   = NUM_TESTS * 80;    // Bounds the slowest divide.

  logic                 clk;
  logic                 ar;
  logic                 req;
  int_arith_pkg::op_e   op;
  int_arith_pkg::word_t a;
  int_arith_pkg::word_t b;
  logic                 ack;
  logic                 busy;
  int_arith_pkg::word_t result;
  logic                 carry;
  logic                 overflow;
  logic                 div_zero;
  int                   cycle       = 0; // Counted at each falling edge.
  int                   error_count = 0;
  int                   check_count = 0;
  logic [31:0]          lcg_state   = 32'h65fc;

  `include "tb_arith_ref.svh"

  expect_t exp_q [$];   // Pending answers, oldest first.
  int      lat_q [$];
  int      issue_q [$]; // Cycle in which req was high.

  arith_unit i_arith_unit (
    .clk(clk), .ar(ar), .req(req), .op(op), .a(a), .b(b),
    .ack(ack), .busy(busy), .result(result), .carry(carry),
    .overflow(overflow), .div_zero(div_zero)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ----------------------------------------------------------
  // One request on an idle coprocessor, expected answer queued.
  task automatic issue_op(input int_arith_pkg::op_e o, input int_arith_pkg::word_t x,
                          input int_arith_pkg::word_t y);
    do @(negedge clk); while (busy || exp_q.size() != 0);
    @(posedge clk);
    req <= 1'b1;
    op  <= o;
    a   <= x;
    b   <= y;
    exp_q.push_back(reference_result(o, x, y));
    lat_q.push_back(expected_latency(o, y));
    issue_q.push_back(cycle + 1); // Next falling edge numbers this cycle.
    @(posedge clk);
    req <= 1'b0;
  endtask

  // A req pulse during a pending operation, which must be dropped.
  task automatic drop_while_busy(input int_arith_pkg::op_e o, input int_arith_pkg::word_t x,
                                 input int_arith_pkg::word_t y);
    do @(negedge clk); while (!busy);
    @(posedge clk);
    req <= 1'b1;
    op  <= o;
    a   <= x;
    b   <= y;
    @(posedge clk);
    req <= 1'b0;
  endtask

  // ----------------------------------------------------------
  // Stimulus.
  initial begin : stimulus
    int_arith_pkg::word_t corner [3];
    int_arith_pkg::op_e   mul_ops [3];
    int_arith_pkg::op_e   udiv_ops [2];
    int_arith_pkg::op_e   sdiv_ops [2];
    int_arith_pkg::op_e   div_ops [4];
    int_arith_pkg::word_t s;
    int_arith_pkg::word_t x;
    int_arith_pkg::word_t y;
    ar  = 1'b1;
    req = 1'b0;
    op  = int_arith_pkg::OP_ADD;
    a   = '0;
    b   = '0;
    corner   = '{32'h0, 32'hffff_ffff, 32'h8000_0000};
    mul_ops  = '{int_arith_pkg::OP_MUL_LO, int_arith_pkg::OP_MUL_HI_U,
                 int_arith_pkg::OP_MUL_HI_S};
    udiv_ops = '{int_arith_pkg::OP_DIV_U, int_arith_pkg::OP_REM_U};
    sdiv_ops = '{int_arith_pkg::OP_DIV_S, int_arith_pkg::OP_REM_S};
    div_ops  = '{int_arith_pkg::OP_DIV_U, int_arith_pkg::OP_REM_U,
                 int_arith_pkg::OP_DIV_S, int_arith_pkg::OP_REM_S};
    repeat (RESET_CYCLES) @(posedge clk);
    ar <= 1'b0;
    @(negedge clk); // Idle state out of reset.
    check_value("ack after reset", ack, 1'b0);
    check_value("busy after reset", busy, 1'b0);
    check_value("result after reset", result, '0);
    check_value("flags after reset", {carry, overflow, div_zero}, '0);
    // Adder, random then carry and overflow corners.
    repeat (N_RANDOM) issue_op(int_arith_pkg::OP_ADD, next_random(), next_random());
    issue_op(int_arith_pkg::OP_ADD, 32'hffff_ffff, 32'd1);
    issue_op(int_arith_pkg::OP_ADD, 32'h7fff_ffff, 32'd1);
    issue_op(int_arith_pkg::OP_ADD, 32'h8000_0000, 32'h8000_0000);
    issue_op(int_arith_pkg::OP_ADD, 32'h7fff_ffff, 32'h7fff_ffff);
    // Multiplier.
    foreach (mul_ops[k]) begin
      foreach (corner[i]) begin
        foreach (corner[j]) issue_op(mul_ops[k], corner[i], corner[j]);
      end
      repeat (N_RANDOM) issue_op(mul_ops[k], next_random(), next_random());
    end
    // Unsigned divide, divisors of mixed size.
    foreach (udiv_ops[k]) begin
      repeat (N_RANDOM) begin
        s = next_random();
        x = next_random();
        y = next_random() >> s[4:0];
        issue_op(udiv_ops[k], x, y);
      end
      issue_op(udiv_ops[k], next_random(), 32'd1);
      s = next_random();
      issue_op(udiv_ops[k], s >> 8, s | 32'h8000_0000); // Divisor above dividend.
    end
    // Signed divide, every sign pair and the most negative over -1.
    foreach (sdiv_ops[k]) begin
      issue_op(sdiv_ops[k], 32'd7, 32'd2);
      issue_op(sdiv_ops[k], -32'sd7, 32'd2);
      issue_op(sdiv_ops[k], 32'd7, -32'sd2);
      issue_op(sdiv_ops[k], -32'sd7, -32'sd2);
      issue_op(sdiv_ops[k], 32'h8000_0000, 32'hffff_ffff);
      repeat (N_RANDOM) begin
        s = next_random();
        x = next_random();
        y = $signed(next_random()) >>> s[4:0]; // Keeps the sign.
        issue_op(sdiv_ops[k], x, y);
      end
    end
    // Divide by zero, each time after an add that sets carry and overflow.
    foreach (div_ops[k]) begin
      issue_op(int_arith_pkg::OP_ADD, 32'h8000_0000, 32'h8000_0000);
      issue_op(div_ops[k], next_random(), '0);
      issue_op(div_ops[k], 32'h8000_0000, '0);
    end
    // Long divide with a request dropped while it runs.
    issue_op(int_arith_pkg::OP_DIV_U, 32'hffff_ffff, 32'd3);
    drop_while_busy(int_arith_pkg::OP_ADD, 32'd5, 32'd6);
    do @(negedge clk); while (busy || exp_q.size() != 0);
    repeat (20) @(negedge clk); // Room for a stray ack.
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // ----------------------------------------------------------
  // Comparison at the falling edge, cycle count and timeout.
  initial begin : compare
    expect_t e;
    int      lat;
    int      start;
    while (cycle < MAX_CYCLES) begin
      @(negedge clk);
      cycle++;
      if (exp_q.size() != 0 && cycle > issue_q[0]) begin
        check_value("busy while pending", busy, 1'b1); // Through the ack cycle.
      end
      if (ack) begin
        if (exp_q.size() == 0) begin
          error_count++;
          $display("Unexpected ack at %0t ns with no request pending", $time);
        end else begin
          e     = exp_q.pop_front();
          lat   = lat_q.pop_front();
          start = issue_q.pop_front();
          check_value("result", result, e.result);
          check_value("carry", carry, e.carry);
          check_value("overflow", overflow, e.overflow);
          check_value("div_zero", div_zero, e.div_zero);
          if (lat > 0) check_value("ack latency", cycle - start, lat);
        end
      end
    end
    $display("Timeout after %0d cycles, the coprocessor stopped answering", MAX_CYCLES);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule
